/* hdl/tcb_arbiter.sv */
// round-robin requester select for the shared memory port, held stable while a transfer stalls
`timescale 1ns/1ns

module tcb_arbiter #(
  parameter  int unsigned SPN = 2,          // number of requesters
  localparam int unsigned SPL = $clog2(SPN) // select width
)(
  input  logic           man,       // clock
  input  logic           rst_n,     // sync reset, active low
  input  logic [SPN-1:0] vld,       // request valid per port
  input  logic           rdy,       // memory ready
  output logic [SPL-1:0] sel        // granted port
);

  typedef enum logic {
    ARB_IDLE,  // free to pick a new winner
    ARB_HOLD   // winner stalled, grant locked
  } arb_state_t;

  arb_state_t     state;
  logic [SPL-1:0] ptr;   // highest priority port
  logic [SPL-1:0] lck;   // locked grant during a stall
  logic [SPL-1:0] pick;  // search result
  logic           trn;   // transfer on the memory port
  int             idx;

  //////////////////////////////////////////////////
  // search from the pointer
  //////////////////////////////////////////////////

  // walk backwards so the nearest valid port after ptr wins
  always_comb begin
    pick = ptr;  // nothing valid, park on ptr
    for (int k = SPN-1; k >= 0; k--) begin
      idx = (int'(ptr) + k) % SPN;
      if (vld[idx]) pick = idx[SPL-1:0];
    end
  end

  assign sel = (state == ARB_HOLD) ? lck : pick;  // no change while stalled
  assign trn = vld[sel] & rdy;

  //////////////////////////////////////////////////
  // lock and rotate
  //////////////////////////////////////////////////

  always_ff @(posedge man) begin
    if (!rst_n) begin
      state <= ARB_IDLE;
      ptr   <= '0;
      lck   <= '0;
    end else begin
      if (trn) begin
        ptr   <= SPL'((int'(sel) + 1) % SPN);  // next port after the served one
        state <= ARB_IDLE;
      end else if (vld[sel]) begin
        // granted port waits on ready, freeze the grant
        state <= ARB_HOLD;
        lck   <= sel;
      end
    end
  end

endmodule: tcb_arbiter

/* hdl/tcb_memory.sv */
// word memory behind the bus, byte-masked writes and registered one-cycle reads
`timescale 1ns/1ns

module tcb_memory (
  input  logic          man,    // clock
  input  logic          rst_n,  // sync reset, active low
  input  logic          hold,   // external stall
  input  logic          vld,    // request valid
  input  logic          wen,    // 1 write, 0 read
  input  tcb_pkg::adr_t adr,    // word address
  input  tcb_pkg::ben_t ben,    // byte lanes to write
  input  tcb_pkg::dat_t wdt,    // write data
  output logic          rdy,    // request accepted
  output tcb_pkg::dat_t rdt     // read data, one cycle late
);

  import tcb_pkg::*;

  localparam int unsigned DEPTH = 2**ABW;

  dat_t mem [DEPTH];  // contents undefined until written
  logic run;          // out of reset
  logic trn;          // transfer this cycle

  //////////////////////////////////////////////////
  // handshake
  //////////////////////////////////////////////////

  // run stays low through reset, so ready does too
  always_ff @(posedge man) begin
    if (!rst_n) begin
      run <= 1'b0;
    end else begin
      run <= 1'b1;
    end
  end

  assign rdy = run & ~hold;  // hold is the back-pressure source
  assign trn = vld & rdy;

  //////////////////////////////////////////////////
  // storage
  //////////////////////////////////////////////////

  // write only the enabled lanes
  always_ff @(posedge man) begin
    if (trn && wen) begin
      for (int b = 0; b < BEW; b++) begin
        if (ben[b]) mem[adr][8*b +: 8] <= wdt[8*b +: 8];
      end
    end
  end

  // registered read, old word on same-edge write
  always_ff @(posedge man) begin
    if (trn && !wen) begin
      rdt <= mem[adr];
    end
  end

endmodule: tcb_memory

/* hdl/tcb_multiplexer.sv */
// steers the granted requester onto the memory port and returns ready and read data to it
`timescale 1ns/1ns

module tcb_multiplexer #(
  parameter  int unsigned SPN = 2,           // number of requesters
  localparam int unsigned SPL = $clog2(SPN)  // select width
)(
  input  logic           man,               // clock
  input  logic           rst_n,             // sync reset, active low
  input  logic [SPL-1:0] sel,               // grant from the arbiter
  // requester side
  input  logic           sub_vld [SPN-1:0],
  input  logic           sub_wen [SPN-1:0],
  input  tcb_pkg::adr_t  sub_adr [SPN-1:0],
  input  tcb_pkg::ben_t  sub_ben [SPN-1:0],
  input  tcb_pkg::dat_t  sub_wdt [SPN-1:0],
  output logic           sub_rdy [SPN-1:0],
  output tcb_pkg::dat_t  sub_rdt [SPN-1:0],
  // memory side
  output logic           mem_vld,
  output logic           mem_wen,
  output tcb_pkg::adr_t  mem_adr,
  output tcb_pkg::ben_t  mem_ben,
  output tcb_pkg::dat_t  mem_wdt,
  input  logic           mem_rdy,
  input  tcb_pkg::dat_t  mem_rdt
);

  logic [SPL-1:0] rsp_sel;  // owner of the response in flight
  logic           trn;      // memory port transfer

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  // plain index into the loose arrays, same cycle
  assign mem_vld = sub_vld[sel];
  assign mem_wen = sub_wen[sel];
  assign mem_adr = sub_adr[sel];
  assign mem_ben = sub_ben[sel];
  assign mem_wdt = sub_wdt[sel];

  assign trn = mem_vld & mem_rdy;

  //////////////////////////////////////////////////
  // response select
  //////////////////////////////////////////////////

  // remembers who asked, so the next request can
  // already be routed while this data comes back
  always_ff @(posedge man) begin
    if (!rst_n) begin
      rsp_sel <= '0;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  //////////////////////////////////////////////////
  // per-port ready and read data
  //////////////////////////////////////////////////

  for (genvar i = 0; i < SPN; i++) begin: gen_port
    // only the granted port sees ready
    assign sub_rdy[i] = (sel == i[SPL-1:0]) ? mem_rdy : 1'b0;
    // data goes back to the port of the previous transfer
    assign sub_rdt[i] = (rsp_sel == i[SPL-1:0]) ? mem_rdt : '0;
  end: gen_port

endmodule: tcb_multiplexer

/* hdl/tcb_pkg.sv */
// shared bus widths and vector types, imported by every RTL block and the testbench
package tcb_pkg;

  //////////////////////////////////////////////////
  // bus geometry
  //////////////////////////////////////////////////

  // word address width for 256 words
  localparam int unsigned ABW = 8;

  // data word width
  localparam int unsigned DBW = 32;

  // one enable per byte lane
  localparam int unsigned BEW = DBW / 8;

  //////////////////////////////////////////////////
  // vector types
  //////////////////////////////////////////////////

  // word address counted in words
  typedef logic [ABW-1:0] adr_t;

  // data word in both directions
  typedef logic [DBW-1:0] dat_t;

  // byte enable mask where bit b covers dat_t[8*b +: 8]
  typedef logic [BEW-1:0] ben_t;

  // bus rules these types travel with
  //   transfer   = vld & rdy on a rising clock edge
  //   read data  = valid exactly one cycle after the read transfer
  //   write      = no response at all

endpackage: tcb_pkg

/* hdl/tcb_subsystem.sv */
// top level of the shared memory subsystem, requesters arbitrated onto one memory
`timescale 1ns/1ns

module tcb_subsystem #(
  parameter int unsigned SPN = 2  // number of requesters
)(
  input  logic          man,    // clock
  input  logic          rst_n,  // sync reset, active low
  input  logic          hold,   // memory stall
  // requester ports
  input  logic          sub_vld [SPN-1:0],
  input  logic          sub_wen [SPN-1:0],
  input  tcb_pkg::adr_t sub_adr [SPN-1:0],
  input  tcb_pkg::ben_t sub_ben [SPN-1:0],
  input  tcb_pkg::dat_t sub_wdt [SPN-1:0],
  output logic          sub_rdy [SPN-1:0],
  output tcb_pkg::dat_t sub_rdt [SPN-1:0]
);

  import tcb_pkg::*;

  localparam int unsigned SPL = $clog2(SPN);

  logic [SPL-1:0] sel;      // current grant
  logic [SPN-1:0] vld_vec;  // packed valids for the arbiter

  // memory port
  logic mem_vld;
  logic mem_wen;
  adr_t mem_adr;
  ben_t mem_ben;
  dat_t mem_wdt;
  logic mem_rdy;
  dat_t mem_rdt;

  for (genvar i = 0; i < SPN; i++) begin: gen_vld
    assign vld_vec[i] = sub_vld[i];
  end: gen_vld

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  tcb_arbiter #(.SPN(SPN)) u_arb (
    .man(man), .rst_n(rst_n), .vld(vld_vec), .rdy(mem_rdy), .sel(sel)
  );

  tcb_multiplexer #(.SPN(SPN)) u_mux (
    .man(man), .rst_n(rst_n), .sel(sel),
    .sub_vld(sub_vld), .sub_wen(sub_wen), .sub_adr(sub_adr),
    .sub_ben(sub_ben), .sub_wdt(sub_wdt),
    .sub_rdy(sub_rdy), .sub_rdt(sub_rdt),
    .mem_vld(mem_vld), .mem_wen(mem_wen), .mem_adr(mem_adr),
    .mem_ben(mem_ben), .mem_wdt(mem_wdt),
    .mem_rdy(mem_rdy), .mem_rdt(mem_rdt)
  );

  tcb_memory u_mem (
    .man(man), .rst_n(rst_n), .hold(hold),
    .vld(mem_vld), .wen(mem_wen), .adr(mem_adr), .ben(mem_ben), .wdt(mem_wdt),
    .rdy(mem_rdy), .rdt(mem_rdt)
  );

endmodule: tcb_subsystem

/* sim.f */
hdl/tcb_pkg.sv
hdl/tcb_arbiter.sv
hdl/tcb_multiplexer.sv
hdl/tcb_memory.sv
hdl/tcb_subsystem.sv
tb/tcb_checker.sv
tb/tcb_subsystem_tb.sv

/* tb/tcb_checker.sv */
// testbench monitor that mirrors the memory behind the subsystem ports and counts errors
`timescale 1ns/1ns

module tcb_checker #(
  parameter int unsigned SPN = 2  // number of requesters
)(
  input  logic          man,                // clock
  input  logic          rst_n,              // sync reset, active low
  input  logic          hold,               // memory stall
  input  logic          sub_vld [SPN-1:0],
  input  logic          sub_wen [SPN-1:0],
  input  tcb_pkg::adr_t sub_adr [SPN-1:0],
  input  tcb_pkg::ben_t sub_ben [SPN-1:0],
  input  tcb_pkg::dat_t sub_wdt [SPN-1:0],
  input  logic          sub_rdy [SPN-1:0],
  input  tcb_pkg::dat_t sub_rdt [SPN-1:0],
  output int            dat_err,            // wrong read data
  output int            prt_err,            // handshake rule breaks
  output int            xfer_cnt            // accepted transfers
);

  import tcb_pkg::*;

  localparam int unsigned DEPTH = 2**ABW;

  dat_t ref_mem [DEPTH];   // model of the memory contents
  ben_t wr_msk  [DEPTH];   // lanes written at least once
  logic rst_seen  = 1'b0;  // ready is known after the first reset edge
  logic pnd       = 1'b0;  // read response due at this edge
  int   pnd_port;          // port that issued that read
  adr_t pnd_adr;
  dat_t pnd_exp;           // reference word with unwritten lanes zeroed
  dat_t pnd_msk;
  int   last_port = -1;    // winner of the previous transfer
  int   own       = -1;    // port locked by a stall

  initial begin
    dat_err  = 0;
    prt_err  = 0;
    xfer_cnt = 0;
    for (int a = 0; a < DEPTH; a++) wr_msk[a] = '0;  // nothing written yet
  end

  // byte enables spread to a bit mask
  function automatic dat_t lane_mask(input ben_t ben);
    dat_t m;
    for (int b = 0; b < BEW; b++) m[8*b +: 8] = {8{ben[b]}};
    return m;
  endfunction

  //////////////////////////////////////////////////
  // sampled at the transfer edge
  //////////////////////////////////////////////////

  always @(posedge man) begin : watch
    int nrdy;
    int exp_port;
    int won;
    int q;
    nrdy     = 0;
    exp_port = -1;
    won      = -1;
    for (int i = 0; i < SPN; i++) begin
      nrdy += (sub_rdy[i] === 1'b1);
    end
    if (!rst_n) begin
      for (int i = 0; i < SPN; i++) begin
        if (rst_seen && sub_rdy[i] !== 1'b0) begin
          $display("port %0d shows ready while reset is asserted", i);
          prt_err++;
        end
      end
      rst_seen = 1'b1;
    end else begin
      if (hold && nrdy != 0) begin  // stall must block every port
        $display("a port shows ready while hold is set");
        prt_err++;
      end
      if (nrdy > 1) begin
        $display("more than one port shows ready in the same cycle");
        prt_err++;
      end
      // data for the read accepted one edge ago
      if (pnd) begin
        for (int i = 0; i < SPN; i++) begin
          if (i == pnd_port) begin
            if ((sub_rdt[i] & pnd_msk) !== pnd_exp) begin
              $display("FAIL sub_rdt[%0d] adr %02h expected %08h actual %08h",
                       i, pnd_adr, pnd_exp, sub_rdt[i]);
              dat_err++;
            end
          end else if (sub_rdt[i] !== '0) begin
            $display("port %0d received read data issued by port %0d", i, pnd_port);
            prt_err++;
          end
        end
      end
      pnd = 1'b0;
      // grant due now is the stalled owner or the next valid port after the last winner
      if (own >= 0) begin
        exp_port = own;
      end else begin
        for (int k = 1; k <= SPN; k++) begin
          q = (last_port + k) % int'(SPN);
          if (exp_port < 0 && sub_vld[q] === 1'b1) exp_port = q;
        end
      end
      // at most one new transfer per edge
      for (int i = 0; i < SPN; i++) begin
        if (sub_vld[i] === 1'b1 && sub_rdy[i] === 1'b1) begin
          xfer_cnt++;
          won = i;
          if (sub_wen[i]) begin
            for (int b = 0; b < BEW; b++) begin
              if (sub_ben[i][b]) begin
                ref_mem[sub_adr[i]][8*b +: 8] = sub_wdt[i][8*b +: 8];
                wr_msk[sub_adr[i]][b] = 1'b1;
              end
            end
          end else begin
            pnd      = 1'b1;
            pnd_port = i;
            pnd_adr  = sub_adr[i];
            pnd_msk  = lane_mask(wr_msk[sub_adr[i]]);
            pnd_exp  = ref_mem[sub_adr[i]] & pnd_msk;  // old word before any same-edge write
          end
        end
      end
      if (won >= 0) begin
        if (won != exp_port) begin
          $display("port %0d won the bus where port %0d was due", won, exp_port);
          prt_err++;
        end
        last_port = won;
        own       = -1;
      end else if (exp_port >= 0) begin
        own = exp_port;  // stalled so the grant must stay
      end
    end
  end

endmodule: tcb_checker

/* tb/tcb_subsystem_tb.sv */
// testbench top that runs a request table with stalls on both ports of the memory subsystem
`timescale 1ns/1ns

module tcb_subsystem_tb;

  import tcb_pkg::*;

  localparam int unsigned SPN  = 2;
  localparam int          TMO  = 50;  // cycles allowed for ready
  localparam int          NROW = 14;

  typedef struct packed {
    logic       port;  // requester that issues the row
    logic       wen;   // 1 write, 0 read
    adr_t       adr;
    ben_t       ben;
    logic [3:0] hld;   // hold cycles from the request on
    logic       cmp;   // other port also reads the same word
  } row_t;

  logic man = 1'b0;
  logic rst_n;
  logic hold;
  logic sub_vld [SPN-1:0];
  logic sub_wen [SPN-1:0];
  adr_t sub_adr [SPN-1:0];
  ben_t sub_ben [SPN-1:0];
  dat_t sub_wdt [SPN-1:0];
  logic sub_rdy [SPN-1:0];
  dat_t sub_rdt [SPN-1:0];

  int          dat_err;
  int          prt_err;
  int          xfer_cnt;
  int          tmo_cnt = 0;
  int          cnt_err = 0;
  logic [31:0] lfsr    = 32'd71;  // write data source
  row_t        rows [NROW];

  always #4 man = ~man;  // 8 ns period

  tcb_subsystem #(.SPN(SPN)) dut (
    .man(man), .rst_n(rst_n), .hold(hold),
    .sub_vld(sub_vld), .sub_wen(sub_wen), .sub_adr(sub_adr),
    .sub_ben(sub_ben), .sub_wdt(sub_wdt),
    .sub_rdy(sub_rdy), .sub_rdt(sub_rdt)
  );

  tcb_checker #(.SPN(SPN)) u_chk (
    .man(man), .rst_n(rst_n), .hold(hold),
    .sub_vld(sub_vld), .sub_wen(sub_wen), .sub_adr(sub_adr),
    .sub_ben(sub_ben), .sub_wdt(sub_wdt),
    .sub_rdy(sub_rdy), .sub_rdt(sub_rdt),
    .dat_err(dat_err), .prt_err(prt_err), .xfer_cnt(xfer_cnt)
  );

  //////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////

  // galois lfsr stepped once per data bit
  function automatic dat_t rand_word();
    dat_t w;
    for (int n = 0; n < DBW; n++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      w[n] = lfsr[0];
    end
    return w;
  endfunction

  // starts on a falling edge and returns on the falling edge after the transfer
  task automatic drive_request(input int p, input logic wen, input adr_t adr,
                               input ben_t ben, input dat_t wdt);
    int n;
    sub_vld[p] = 1'b1;
    sub_wen[p] = wen;
    sub_adr[p] = adr;
    sub_ben[p] = ben;
    sub_wdt[p] = wdt;
    n = 0;
    while (n < TMO) begin
      @(posedge man);
      if (sub_rdy[p] === 1'b1) break;  // our vld is high so this edge is the transfer
      n++;
    end
    if (n == TMO) begin
      $display("port %0d timed out waiting for ready", p);
      tmo_cnt++;
    end
    @(negedge man);
    sub_vld[p] = 1'b0;
  endtask

  task automatic release_hold(input int cycles);
    repeat (cycles) @(negedge man);
    hold = 1'b0;
  endtask

  //////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////

  initial begin
    int   exp_xfer;
    dat_t wdt;
    exp_xfer = 0;
    rst_n    = 1'b0;
    hold     = 1'b0;
    for (int i = 0; i < SPN; i++) begin
      sub_vld[i] = 1'b0;
      sub_wen[i] = 1'b0;
      sub_adr[i] = '0;
      sub_ben[i] = '0;
      sub_wdt[i] = '0;
    end
    rows = '{
      '{1'b0, 1'b1, 8'h10, 4'hf, 4'd0, 1'b0},  // full write then read back
      '{1'b0, 1'b0, 8'h10, 4'hf, 4'd0, 1'b0},
      '{1'b1, 1'b1, 8'h22, 4'hf, 4'd0, 1'b0},
      '{1'b1, 1'b0, 8'h22, 4'hf, 4'd0, 1'b0},
      '{1'b0, 1'b1, 8'h10, 4'h5, 4'd0, 1'b0},  // partial write
      '{1'b1, 1'b0, 8'h10, 4'hf, 4'd0, 1'b0},  // merged word
      '{1'b1, 1'b1, 8'h22, 4'h8, 4'd3, 1'b0},  // stalled write
      '{1'b0, 1'b0, 8'h22, 4'hf, 4'd2, 1'b0},  // stalled read
      '{1'b0, 1'b1, 8'h30, 4'hf, 4'd0, 1'b1},  // write against a read
      '{1'b1, 1'b0, 8'h10, 4'hf, 4'd0, 1'b1},  // back to back reads
      '{1'b0, 1'b0, 8'h22, 4'hf, 4'd4, 1'b1},  // rival arrives during the stall
      '{1'b1, 1'b1, 8'h30, 4'h3, 4'd0, 1'b1},
      '{1'b0, 1'b0, 8'h30, 4'hf, 4'd0, 1'b1},
      '{1'b1, 1'b0, 8'h30, 4'hf, 4'd1, 1'b0}
    };

    // reset with both ports requesting
    @(negedge man);
    for (int i = 0; i < SPN; i++) sub_vld[i] = 1'b1;
    repeat (7) @(negedge man);
    for (int i = 0; i < SPN; i++) sub_vld[i] = 1'b0;
    repeat (2) @(negedge man);
    rst_n = 1'b1;

    for (int r = 0; r < NROW; r++) begin
      @(negedge man);
      hold = (rows[r].hld != 0);
      wdt  = rand_word();
      fork
        drive_request(rows[r].port, rows[r].wen, rows[r].adr, rows[r].ben, wdt);
        if (rows[r].cmp) begin
          if (rows[r].hld != 0) @(negedge man);  // rival shows up once the grant is locked
          drive_request(rows[r].port ? 0 : 1, 1'b0, rows[r].adr, '1, '0);
        end
        release_hold(rows[r].hld);
      join
      exp_xfer += 1 + rows[r].cmp;
    end
    repeat (2) @(negedge man);  // last response compared

    if (xfer_cnt != exp_xfer) begin
      $display("saw %0d transfers where the table issues %0d", xfer_cnt, exp_xfer);
      cnt_err++;
    end
    $display("errors: data %0d protocol %0d timeout %0d count %0d",
             dat_err, prt_err, tmo_cnt, cnt_err);
    if (dat_err + prt_err + tmo_cnt + cnt_err == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule: tcb_subsystem_tb
